//--- include/board_params.svh
/*
 * Width macros for the board I/O adapter.
 * Included by the packages and by RTL that loops over buses.
 */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Flattened pinmux vector widths.
`define BOARD_OUT_PINS_W 16
`define BOARD_IN_PINS_W 8
`define BOARD_INOUT_PINS_W 24

// Modeled I2C buses: QWIIC1, HAT ID, HAT secondary.
`define BOARD_I2C_BUSES 3

// Pin-to-pin loopback paths.
`define BOARD_LOOPBACK_W 6

// CHERI error indicator bits.
`define BOARD_CHERI_ERR_W 9

`endif

//--- hdl/board_dev_pkg.sv
/*
 * Device-side types of the board I/O adapter.
 * Covers I2C line vectors, the loopback vector and the CHERI error vector.
 */
`default_nettype none

`include "board_params.svh"

package board_dev_pkg;

  // One bit per bus.
  // Bit 0 is QWIIC1, bit 1 the HAT ID bus, bit 2 the HAT secondary bus.
  typedef logic [`BOARD_I2C_BUSES-1:0] i2c_lines_t;

  // Loopback sources, MSB first.
  // AH_TMPIO8, AH_TMPIO1, MB10, MB7, MB4, PMOD0_8.
  typedef logic [`BOARD_LOOPBACK_W-1:0] loopback_t;

  // CHERI error indicators, one per exception class.
  typedef logic [`BOARD_CHERI_ERR_W-1:0] cheri_err_t;

endpackage

`default_nettype wire

//--- hdl/board_pins_pkg.sv
/*
 * Pin-vector types and bit positions of the flattened pinmux vectors.
 * Imported by the blocks that pick pins out of these vectors or place values into them.
 */
`default_nettype none

`include "board_params.svh"

package board_pins_pkg;

  // Pin vectors as seen from the system side.
  typedef logic [`BOARD_OUT_PINS_W-1:0]   out_pins_t;
  typedef logic [`BOARD_IN_PINS_W-1:0]    in_pins_t;
  typedef logic [`BOARD_INOUT_PINS_W-1:0] inout_pins_t;

  // Output-only pins.
  parameter int unsigned OUT_PIN_SER0_TX = 0;
  parameter int unsigned OUT_PIN_MB4     = 5;
  parameter int unsigned OUT_PIN_MB7     = 8;
  parameter int unsigned OUT_PIN_MB10    = 11;

  // Input-only pins.
  parameter int unsigned IN_PIN_SER0_RX = 0;
  parameter int unsigned IN_PIN_MB3     = 3;
  parameter int unsigned IN_PIN_MB8     = 6;

  // Bidirectional pins, I2C first.
  parameter int unsigned INOUT_PIN_SCL1       = 0;
  parameter int unsigned INOUT_PIN_SDA1       = 1;
  parameter int unsigned INOUT_PIN_RPH_G0     = 2;
  parameter int unsigned INOUT_PIN_RPH_G1     = 3;
  parameter int unsigned INOUT_PIN_RPH_G2_SDA = 4;
  parameter int unsigned INOUT_PIN_RPH_G3_SCL = 5;
  // SPI on PMOD1: CS, COPI, CIPO, SCK.
  parameter int unsigned INOUT_PIN_PMOD1_1    = 6;
  parameter int unsigned INOUT_PIN_PMOD1_2    = 7;
  parameter int unsigned INOUT_PIN_PMOD1_3    = 8;
  parameter int unsigned INOUT_PIN_PMOD1_4    = 9;
  parameter int unsigned INOUT_PIN_PMOD0_1    = 10;
  parameter int unsigned INOUT_PIN_PMOD0_8    = 11;
  parameter int unsigned INOUT_PIN_PMOD0_10   = 12;
  parameter int unsigned INOUT_PIN_AH_TMPIO0  = 13;
  parameter int unsigned INOUT_PIN_AH_TMPIO1  = 14;
  parameter int unsigned INOUT_PIN_AH_TMPIO8  = 15;
  parameter int unsigned INOUT_PIN_AH_TMPIO9  = 16;

  // Clock and data pin of each I2C bus, indexed in i2c_lines_t order.
  // The HAT ID bus puts SDA on GPIO0 and SCL on GPIO1.
  parameter int unsigned I2C_SCL_PIN [`BOARD_I2C_BUSES] =
    '{INOUT_PIN_SCL1, INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL};
  parameter int unsigned I2C_SDA_PIN [`BOARD_I2C_BUSES] =
    '{INOUT_PIN_SDA1, INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA};

endpackage

`default_nettype wire

//--- hdl/board_link_if.sv
/*
 * Internal link from the pin decoder to the encoder and the loopback retimer.
 * Carries resolved open-drain bus lines and the raw loopback sources.
 */
`timescale 1ns/1ps
`default_nettype none

interface board_link_if;
  import board_dev_pkg::*;

  // Controller-side I2C lines after open-drain resolution.
  i2c_lines_t scl_line;
  i2c_lines_t sda_line;

  // PMOD1 SPI controller outputs after resolution.
  logic spi_cs_line;
  logic spi_sck_line;
  logic spi_copi_line;

  // Loopback sources before retiming.
  loopback_t loop_src;

  // Decoder produces every line.
  modport decoder (
    output scl_line, sda_line, spi_cs_line, spi_sck_line, spi_copi_line, loop_src
  );

  // Encoder only needs the I2C lines for the wired-AND readback.
  modport encoder (input scl_line, sda_line);

  modport retimer (input loop_src);

endinterface

`default_nettype wire

//--- hdl/pin_decoder.sv
/*
 * Resolves open-drain drives of the I2C and SPI pins and routes output pins.
 * Fully combinational; feeds the link interface and the UART TX line.
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module pin_decoder (
  input  board_pins_pkg::out_pins_t   out_to_pins_i,
  input  board_pins_pkg::inout_pins_t inout_to_pins_i,
  input  board_pins_pkg::inout_pins_t inout_to_pins_en_i,
  board_link_if.decoder               link,
  output logic                        uart_tx_o
);
  import board_pins_pkg::*;

  // Driven value when enabled, pulled up otherwise.
  function automatic logic od_drive(input logic val, input logic en);
    return en ? val : 1'b1;
  endfunction

  always_comb begin
    for (int b = 0; b < `BOARD_I2C_BUSES; b++) begin
      link.scl_line[b] = od_drive(inout_to_pins_i[I2C_SCL_PIN[b]],
                                  inout_to_pins_en_i[I2C_SCL_PIN[b]]);
      link.sda_line[b] = od_drive(inout_to_pins_i[I2C_SDA_PIN[b]],
                                  inout_to_pins_en_i[I2C_SDA_PIN[b]]);
    end
    // SPI on PMOD1 idles high when not driven.
    link.spi_cs_line   = od_drive(inout_to_pins_i[INOUT_PIN_PMOD1_1],
                                  inout_to_pins_en_i[INOUT_PIN_PMOD1_1]);
    link.spi_copi_line = od_drive(inout_to_pins_i[INOUT_PIN_PMOD1_2],
                                  inout_to_pins_en_i[INOUT_PIN_PMOD1_2]);
    link.spi_sck_line  = od_drive(inout_to_pins_i[INOUT_PIN_PMOD1_4],
                                  inout_to_pins_en_i[INOUT_PIN_PMOD1_4]);
  end

  // Loopback sources, same order as loopback_t.
  assign link.loop_src = {inout_to_pins_i[INOUT_PIN_AH_TMPIO8],
                          inout_to_pins_i[INOUT_PIN_AH_TMPIO1],
                          out_to_pins_i[OUT_PIN_MB10],
                          out_to_pins_i[OUT_PIN_MB7],
                          out_to_pins_i[OUT_PIN_MB4],
                          inout_to_pins_i[INOUT_PIN_PMOD0_8]};

  // System UART transmit.
  assign uart_tx_o = out_to_pins_i[OUT_PIN_SER0_TX];

endmodule

`default_nettype wire

//--- hdl/loopback_retimer.sv
/*
 * Single register stage on the pin-to-pin loopback paths.
 * Breaks the net-level loop from output pins back to input pins.
 */
`timescale 1ns/1ps
`default_nettype none

module loopback_retimer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  board_link_if.retimer             link,
  output board_dev_pkg::loopback_t  loop_q_o
);

  // Sources sampled each edge, visible one cycle later.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loop_q_o <= '0;
    end else begin
      loop_q_o <= link.loop_src;
    end
  end

  // Exactly one cycle of latency from the decoder's sources.
  a_loop_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    1'b1 |=> (loop_q_o == $past(link.loop_src))
  ) else $error("loopback output does not match previous source");

endmodule

`default_nettype wire

//--- hdl/pin_encoder.sv
/*
 * Builds the input pin vectors seen by the system.
 * Combines device lines, wired-AND I2C readback, retimed loopbacks and tie-offs.
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module pin_encoder (
  board_link_if.encoder               link,
  input  board_dev_pkg::loopback_t    loop_q_i,
  input  board_dev_pkg::i2c_lines_t   i2c_scl_dev_i,
  input  board_dev_pkg::i2c_lines_t   i2c_sda_dev_i,
  input  logic                        spi_cipo_i,
  input  logic                        uart_rx_i,
  output board_pins_pkg::in_pins_t    in_from_pins_o,
  output board_pins_pkg::inout_pins_t inout_from_pins_o
);
  import board_pins_pkg::*;

  always_comb begin
    // Tie-offs.
    // Bidirectional pins have board pull-ups, input pins read low.
    inout_from_pins_o = '1;
    in_from_pins_o    = '0;

    // The controller must see its own drive plus the device's drive on the wire.
    for (int b = 0; b < `BOARD_I2C_BUSES; b++) begin
      inout_from_pins_o[I2C_SCL_PIN[b]] = link.scl_line[b] & i2c_scl_dev_i[b];
      inout_from_pins_o[I2C_SDA_PIN[b]] = link.sda_line[b] & i2c_sda_dev_i[b];
    end

    // SPI readback from the PMOD1 peripheral.
    inout_from_pins_o[INOUT_PIN_PMOD1_3] = spi_cipo_i;

    // System UART receive.
    in_from_pins_o[IN_PIN_SER0_RX] = uart_rx_i;

    // Loopback destinations, same bit order as the sources.
    // TMPIO8 to TMPIO9 and TMPIO1 to TMPIO0 on the Arduino header.
    // MB10 PWM to PMOD0_1, MB7 TX to MB8 RX, MB4 COPI to MB3 CIPO.
    // PMOD0_8 to PMOD0_10.
    {inout_from_pins_o[INOUT_PIN_AH_TMPIO9],
     inout_from_pins_o[INOUT_PIN_AH_TMPIO0],
     inout_from_pins_o[INOUT_PIN_PMOD0_1],
     in_from_pins_o[IN_PIN_MB8],
     in_from_pins_o[IN_PIN_MB3],
     inout_from_pins_o[INOUT_PIN_PMOD0_10]} = loop_q_i;
  end

endmodule

`default_nettype wire

//--- hdl/cheri_err_tracker.sv
/*
 * Sticky tracking of CHERI error indicators.
 * Raw indicators are modulated for LEDs and repeat, so each bit pulses once only.
 */
`timescale 1ns/1ps
`default_nettype none

module cheri_err_tracker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  board_dev_pkg::cheri_err_t cheri_err_i,
  output board_dev_pkg::cheri_err_t cheri_new_err_o,
  output board_dev_pkg::cheri_err_t cheri_errored_o
);
  import board_dev_pkg::*;

  // Bits raised now that were never seen before.
  cheri_err_t first_seen;

  assign first_seen = cheri_err_i & ~cheri_errored_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cheri_errored_o <= '0;
      cheri_new_err_o <= '0;
    end else begin
      cheri_errored_o <= cheri_errored_o | cheri_err_i;
      // One-cycle pulse per new bit.
      cheri_new_err_o <= first_seen;
    end
  end

  // A new-error pulse always belongs to a recorded bit.
  a_new_in_errored: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cheri_new_err_o & ~cheri_errored_o) == '0
  ) else $error("new CHERI error pulse without a recorded bit");

  // Recorded bits are sticky until reset.
  a_errored_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    1'b1 |=> (($past(cheri_errored_o) & ~cheri_errored_o) == '0)
  ) else $error("recorded CHERI error bit cleared");

endmodule

`default_nettype wire

//--- hdl/board_io_adapter.sv
/*
 * Top level of the board I/O adapter.
 * Connects the system's flattened pin vectors to I2C, SPI, UART and loopback lines.
 */
`timescale 1ns/1ps
`default_nettype none

module board_io_adapter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // System side pin vectors.
  input  board_pins_pkg::out_pins_t   out_to_pins_i,
  input  board_pins_pkg::inout_pins_t inout_to_pins_i,
  input  board_pins_pkg::inout_pins_t inout_to_pins_en_i,
  output board_pins_pkg::in_pins_t    in_from_pins_o,
  output board_pins_pkg::inout_pins_t inout_from_pins_o,
  // I2C device lines and resolved controller lines.
  input  board_dev_pkg::i2c_lines_t   i2c_scl_dev_i,
  input  board_dev_pkg::i2c_lines_t   i2c_sda_dev_i,
  output board_dev_pkg::i2c_lines_t   i2c_scl_o,
  output board_dev_pkg::i2c_lines_t   i2c_sda_o,
  // PMOD1 SPI.
  input  logic                        spi_cipo_i,
  output logic                        spi_cs_o,
  output logic                        spi_sck_o,
  output logic                        spi_copi_o,
  // System UART.
  input  logic                        uart_rx_i,
  output logic                        uart_tx_o,
  // CHERI error reporting.
  input  board_dev_pkg::cheri_err_t   cheri_err_i,
  output board_dev_pkg::cheri_err_t   cheri_new_err_o,
  output board_dev_pkg::cheri_err_t   cheri_errored_o
);
  import board_dev_pkg::*;

  board_link_if link ();

  // Retimed loopback values.
  loopback_t loop_q;

  pin_decoder u_pin_decoder (
    .out_to_pins_i      (out_to_pins_i),
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .link               (link),
    .uart_tx_o          (uart_tx_o)
  );

  loopback_retimer u_loopback_retimer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .link     (link),
    .loop_q_o (loop_q)
  );

  pin_encoder u_pin_encoder (
    .link              (link),
    .loop_q_i          (loop_q),
    .i2c_scl_dev_i     (i2c_scl_dev_i),
    .i2c_sda_dev_i     (i2c_sda_dev_i),
    .spi_cipo_i        (spi_cipo_i),
    .uart_rx_i         (uart_rx_i),
    .in_from_pins_o    (in_from_pins_o),
    .inout_from_pins_o (inout_from_pins_o)
  );

  cheri_err_tracker u_cheri_err_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cheri_err_i     (cheri_err_i),
    .cheri_new_err_o (cheri_new_err_o),
    .cheri_errored_o (cheri_errored_o)
  );

  // Resolved lines go straight out to the device models.
  assign i2c_scl_o  = link.scl_line;
  assign i2c_sda_o  = link.sda_line;
  assign spi_cs_o   = link.spi_cs_line;
  assign spi_sck_o  = link.spi_sck_line;
  assign spi_copi_o = link.spi_copi_line;

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Free-running clock, active-low reset released on a falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge so no flop sees it mid-sample.
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_board_io_adapter.sv
/*
 * Random-stimulus testbench for the board I/O adapter.
 * Drives all inputs after each rising edge and checks against a local model on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module tb_board_io_adapter;
  import board_pins_pkg::*;
  import board_dev_pkg::*;

  localparam int unsigned CLK_PERIOD_NS  = 100;
  localparam int unsigned RESET_CYCLES   = 16;
  localparam int unsigned NUM_CYCLES     = 2000;
  localparam int unsigned TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 50;

  // Bus pin positions in i2c_lines_t order.
  localparam int unsigned SCL_POS [`BOARD_I2C_BUSES] =
    '{INOUT_PIN_SCL1, INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL};
  localparam int unsigned SDA_POS [`BOARD_I2C_BUSES] =
    '{INOUT_PIN_SDA1, INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA};

  logic        clk;
  logic        rst_n;
  out_pins_t   out_d;
  inout_pins_t inout_d;
  inout_pins_t en_d;
  i2c_lines_t  scl_dev_d;
  i2c_lines_t  sda_dev_d;
  logic        cipo_d;
  logic        uart_rx_d;
  cheri_err_t  err_d;
  in_pins_t    in_from_pins;
  inout_pins_t inout_from_pins;
  i2c_lines_t  scl_o;
  i2c_lines_t  sda_o;
  logic        spi_cs;
  logic        spi_sck;
  logic        spi_copi;
  logic        uart_tx;
  cheri_err_t  new_err;
  cheri_err_t  errored;

  // Model state: retimed loopback and CHERI record.
  loopback_t   loop_m;
  cheri_err_t  new_m;
  cheri_err_t  errored_m;
  logic [31:0] rng;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  board_io_adapter dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .out_to_pins_i      (out_d),
    .inout_to_pins_i    (inout_d),
    .inout_to_pins_en_i (en_d),
    .in_from_pins_o     (in_from_pins),
    .inout_from_pins_o  (inout_from_pins),
    .i2c_scl_dev_i      (scl_dev_d),
    .i2c_sda_dev_i      (sda_dev_d),
    .i2c_scl_o          (scl_o),
    .i2c_sda_o          (sda_o),
    .spi_cipo_i         (cipo_d),
    .spi_cs_o           (spi_cs),
    .spi_sck_o          (spi_sck),
    .spi_copi_o         (spi_copi),
    .uart_rx_i          (uart_rx_d),
    .uart_tx_o          (uart_tx),
    .cheri_err_i        (err_d),
    .cheri_new_err_o    (new_err),
    .cheri_errored_o    (errored)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Open-drain line: driven value when enabled, else the pull-up.
  function automatic logic pulled_line(input logic val, input logic en);
    return en ? val : 1'b1;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic drive_random();
    rng = xorshift32(rng);
    out_d = rng[15:0];
    scl_dev_d = rng[18:16];
    sda_dev_d = rng[21:19];
    cipo_d = rng[22];
    uart_rx_d = rng[23];
    rng = xorshift32(rng);
    inout_d = rng[23:0];
    rng = xorshift32(rng);
    en_d = rng[23:0];
    // Sparse errors, about one in sixteen per bit.
    for (int i = 0; i < `BOARD_CHERI_ERR_W; i++) begin
      rng = xorshift32(rng);
      err_d[i] = (rng[3:0] == 4'h0);
    end
  endtask

  task automatic check_outputs();
    i2c_lines_t  exp_scl;
    i2c_lines_t  exp_sda;
    inout_pins_t exp_inout;
    in_pins_t    exp_in;
    exp_inout = '1;
    exp_in = '0;
    for (int b = 0; b < `BOARD_I2C_BUSES; b++) begin
      exp_scl[b] = pulled_line(inout_d[SCL_POS[b]], en_d[SCL_POS[b]]);
      exp_sda[b] = pulled_line(inout_d[SDA_POS[b]], en_d[SDA_POS[b]]);
      // Wired-AND with the device side.
      exp_inout[SCL_POS[b]] = exp_scl[b] & scl_dev_d[b];
      exp_inout[SDA_POS[b]] = exp_sda[b] & sda_dev_d[b];
    end
    exp_inout[INOUT_PIN_PMOD1_3] = cipo_d;
    exp_in[IN_PIN_SER0_RX] = uart_rx_d;
    // Loopback destinations, MSB first.
    exp_inout[INOUT_PIN_AH_TMPIO9] = loop_m[5];
    exp_inout[INOUT_PIN_AH_TMPIO0] = loop_m[4];
    exp_inout[INOUT_PIN_PMOD0_1] = loop_m[3];
    exp_in[IN_PIN_MB8] = loop_m[2];
    exp_in[IN_PIN_MB3] = loop_m[1];
    exp_inout[INOUT_PIN_PMOD0_10] = loop_m[0];
    check_eq("i2c_scl_out", 32'(exp_scl), 32'(scl_o));
    check_eq("i2c_sda_out", 32'(exp_sda), 32'(sda_o));
    check_eq("spi_cs", 32'(pulled_line(inout_d[INOUT_PIN_PMOD1_1],
                                       en_d[INOUT_PIN_PMOD1_1])), 32'(spi_cs));
    check_eq("spi_copi", 32'(pulled_line(inout_d[INOUT_PIN_PMOD1_2],
                                         en_d[INOUT_PIN_PMOD1_2])), 32'(spi_copi));
    check_eq("spi_sck", 32'(pulled_line(inout_d[INOUT_PIN_PMOD1_4],
                                        en_d[INOUT_PIN_PMOD1_4])), 32'(spi_sck));
    check_eq("uart_tx", 32'(out_d[OUT_PIN_SER0_TX]), 32'(uart_tx));
    check_eq("inout_pins", 32'(exp_inout), 32'(inout_from_pins));
    check_eq("in_pins", 32'(exp_in), 32'(in_from_pins));
    check_eq("cheri_new_err", 32'(new_m), 32'(new_err));
    check_eq("cheri_errored", 32'(errored_m), 32'(errored));
  endtask

  // Watchdog sized from reset plus test length.
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    rng = 32'h4ea7;
    out_d = '0;
    inout_d = '0;
    en_d = '0;
    scl_dev_d = '0;
    sda_dev_d = '0;
    cipo_d = 1'b0;
    uart_rx_d = 1'b0;
    err_d = '0;
    loop_m = '0;
    new_m = '0;
    errored_m = '0;
    @(posedge rst_n);
    #1;
    check_outputs();
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      // Model registers take what the DUT just sampled.
      loop_m = {inout_d[INOUT_PIN_AH_TMPIO8], inout_d[INOUT_PIN_AH_TMPIO1],
                out_d[OUT_PIN_MB10], out_d[OUT_PIN_MB7], out_d[OUT_PIN_MB4],
                inout_d[INOUT_PIN_PMOD0_8]};
      new_m = err_d & ~errored_m;
      errored_m = errored_m | err_d;
      #1;
      drive_random();
      @(negedge clk);
      check_outputs();
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/board_dev_pkg.sv
hdl/board_pins_pkg.sv
hdl/board_link_if.sv
hdl/pin_decoder.sv
hdl/loopback_retimer.sv
hdl/pin_encoder.sv
hdl/cheri_err_tracker.sv
hdl/board_io_adapter.sv
verif/tb_clock_gen.sv
verif/tb_board_io_adapter.sv

//--- Makefile
# Verilator build and run for the board I/O adapter testbench.

VERILATOR ?= verilator
TOP       ?= tb_board_io_adapter
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line.
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
